//--- tx_thrtl_ctl.f
+incdir+common
common/tx_thrtl_pkg.sv
throttle/tbuf_link_monitor.sv
throttle/cfg_req_monitor.sv
throttle/pm_state_monitor.sv
throttle/thrtl_fsm.sv
source/tx_thrtl_ctl.sv
sim/tb_tx_thrtl_ctl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the run reports success
cd "$(dirname "$0")" &&
verilator --binary --timing -f tx_thrtl_ctl.f --top-module tb_tx_thrtl_ctl -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run_sim: run passed" ||
{ echo "run_sim: run failed"; exit 1; }

//--- sim/tb_tx_thrtl_ctl.sv
`timescale 1ns/1ns
`default_nettype none
`include "tx_thrtl_defs.svh"

module tb_tx_thrtl_ctl;
  import tx_thrtl_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int NUM_PHASES   = 5;
  localparam int PHASE_CYCLES = 2000;
  localparam int GRANT_WAIT   = 150;

  logic        user_clk;
  logic        user_rst;
  axis_beat_t  s_axis_tx;
  logic        user_tcfg_gnt;
  logic        user_turnoff_ok;
  logic [5:0]  trn_tbuf_av;
  logic        trn_tdst_rdy;
  logic        trn_lnk_up;
  logic        trn_tcfg_req;
  link_state_e cfg_pcie_link_state;
  logic        cfg_to_turnoff;
  logic        trn_tcfg_gnt;
  logic        cfg_turnoff_ok;
  logic        tready_thrtl;

  integer      seed;
  int          owed;
  int          tok_count;
  int          waited;

  // Reference model state
  logic        in_pkt;
  logic        seen_up;
  logic        prev_min;
  logic        req_prev;
  logic        gnt_prev;
  logic        l1_watch;
  logic        off_done;
  logic        to_seen;
  logic        uok_seen;
  logic        accepted;
  link_state_e lstate_prev;

  // Values captured for one rising edge
  axis_beat_t  beat_s;
  logic [5:0]  tbuf_s;
  logic        dst_s;
  logic        lnk_s;
  logic        req_s;
  logic        to_s;
  logic        uok_s;
  link_state_e ls_s;
  logic        rdy_b;
  logic        rdy_a;
  logic        gnt_s;
  logic        tok_s;

  tx_thrtl_ctl i_dut (
    .user_clk            (user_clk),
    .user_rst            (user_rst),
    .s_axis_tx           (s_axis_tx),
    .user_tcfg_gnt       (user_tcfg_gnt),
    .user_turnoff_ok     (user_turnoff_ok),
    .trn_tbuf_av         (trn_tbuf_av),
    .trn_tdst_rdy        (trn_tdst_rdy),
    .trn_lnk_up          (trn_lnk_up),
    .trn_tcfg_req        (trn_tcfg_req),
    .cfg_pcie_link_state (cfg_pcie_link_state),
    .cfg_to_turnoff      (cfg_to_turnoff),
    .trn_tcfg_gnt        (trn_tcfg_gnt),
    .cfg_turnoff_ok      (cfg_turnoff_ok),
    .tready_thrtl        (tready_thrtl)
  );

  initial begin
    user_clk = 1'b0;
    forever #(CLK_PERIOD / 2) user_clk = ~user_clk;
  end

  // Bound on the whole run plus some slack for reset
  initial begin
    #((NUM_PHASES * PHASE_CYCLES + 20) * CLK_PERIOD);
    $display("Watchdog expired before all test phases completed");
    stop_failed();
  end

  task automatic stop_failed();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic compare(input int got, input int exp, input string msg);
    if (got != exp) begin
      $display("[ERROR] %0t ns: %s (got %0d, expected %0d)", $time, msg, got, exp);
      stop_failed();
    end
  endtask

  // ------------------------------------------------------------
  // Model update and checks for one rising edge
  // ------------------------------------------------------------

  task automatic check_edge();
    logic out_edge;
    logic min_now;
    accepted = beat_s.tvalid && rdy_b;
    // Outside a packet and not starting one at this edge
    out_edge = !in_pkt && !(accepted && !beat_s.tlast);
    min_now  = (tbuf_s <= `TBUF_AV_MIN);

    // Nothing may flow before the block has come up once
    if (!seen_up)
      compare(rdy_a, 0, "ready high before link up with destination ready");
    if (lnk_s && dst_s)
      seen_up = 1'b1;

    // A packet is never cut after a middle beat
    if (accepted && !beat_s.tlast)
      compare(rdy_a, 1, "ready dropped inside a packet");

    if (prev_min && min_now && out_edge)
      compare(rdy_a, 0, "ready high with buffers at the minimum");
    prev_min = min_now;

    if (accepted)
      in_pkt = !beat_s.tlast;

    // Every request edge is owed one grant
    if (req_s && !req_prev)
      owed++;
    req_prev = req_s;
    if (gnt_s) begin
      compare(owed > 0, 1, "config grant without an open request");
      compare(gnt_prev, 0, "config grant longer than one cycle");
      compare(in_pkt, 0, "config grant inside a packet");
      owed--;
    end
    gnt_prev = gnt_s;

    // L1 entry holds the user off until the link is back in L0
    if (lstate_prev == LINK_L0 && ls_s == LINK_PPM_L1_TRANS && out_edge)
      l1_watch = 1'b1;
    if (l1_watch) begin
      compare(rdy_a, 0, "ready high during L1 excursion");
      if (ls_s == LINK_L0)
        l1_watch = 1'b0;
    end
    lstate_prev = ls_s;

    if (to_s)
      to_seen = 1'b1;
    if (uok_s)
      uok_seen = 1'b1;
    if (tok_s) begin
      compare(to_seen && uok_seen, 1, "turnoff grant without turnoff request");
      compare(tok_count, 0, "more than one turnoff grant");
      tok_count++;
      off_done = 1'b1;
    end
    // After turnoff the user stays stalled for good
    if (off_done)
      compare(rdy_a, 0, "ready high after turnoff grant");
  endtask

  // Called at a falling edge with the new inputs already driven
  task automatic clock_cycle();
    #1;
    beat_s = s_axis_tx;
    tbuf_s = trn_tbuf_av;
    dst_s  = trn_tdst_rdy;
    lnk_s  = trn_lnk_up;
    req_s  = trn_tcfg_req;
    to_s   = cfg_to_turnoff;
    uok_s  = user_turnoff_ok;
    ls_s   = cfg_pcie_link_state;
    rdy_b  = tready_thrtl;
    gnt_s  = trn_tcfg_gnt;
    tok_s  = cfg_turnoff_ok;
    @(negedge user_clk);
    rdy_a = tready_thrtl;
    check_edge();
  endtask

  // A beat that is offered stays until accepted
  task automatic next_beat();
    if (!(s_axis_tx.tvalid && !accepted)) begin
      s_axis_tx.tvalid = (($random(seed) & 3) != 0);
      s_axis_tx.tlast  = (($random(seed) & 3) == 0);
    end
  endtask

  task automatic run_cycles(input int n, input logic rand_dst);
    repeat (n) begin
      next_beat();
      if (rand_dst)
        trn_tdst_rdy = (($random(seed) & 3) != 0);
      clock_cycle();
    end
  endtask

  // Lets the packet in flight end and then stops offering beats
  task automatic idle_stream();
    int n;
    n = 0;
    while ((in_pkt || (s_axis_tx.tvalid && !accepted)) && n < GRANT_WAIT) begin
      next_beat();
      clock_cycle();
      n++;
    end
    if (in_pkt || (s_axis_tx.tvalid && !accepted)) begin
      $display("Packet in flight never completed");
      stop_failed();
    end
    s_axis_tx.tvalid = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  initial begin
    seed                = 32'h51f6;
    user_rst            = 1'b1;
    s_axis_tx           = '0;
    user_tcfg_gnt       = 1'b1;
    user_turnoff_ok     = 1'b0;
    trn_tbuf_av         = 6'd40;
    trn_tdst_rdy        = 1'b0;
    trn_lnk_up          = 1'b0;
    trn_tcfg_req        = 1'b0;
    cfg_pcie_link_state = LINK_L0;
    cfg_to_turnoff      = 1'b0;
    owed        = 0;
    tok_count   = 0;
    in_pkt      = 1'b0;
    seen_up     = 1'b0;
    prev_min    = 1'b0;
    req_prev    = 1'b0;
    gnt_prev    = 1'b0;
    l1_watch    = 1'b0;
    off_done    = 1'b0;
    to_seen     = 1'b0;
    uok_seen    = 1'b0;
    accepted    = 1'b0;
    lstate_prev = LINK_L0;
    repeat (10) @(posedge user_clk);
    @(negedge user_clk);
    user_rst = 1'b0;

    // Phase 1 starts with the link down, then healthy traffic
    run_cycles(6, 1'b0);
    trn_lnk_up   = 1'b1;
    trn_tdst_rdy = 1'b1;
    run_cycles(300, 1'b0);

    // Phase 2 sweeps the buffer count, mostly near the thresholds
    // Each count stays for a few cycles so the minimum throttle can take hold
    repeat (300) begin
      if ($random(seed) & 1)
        trn_tbuf_av = 6'($random(seed) & 7);
      else
        trn_tbuf_av = 6'(8 + ($random(seed) & 31));
      run_cycles(1 + ($random(seed) & 3), 1'b0);
    end
    trn_tbuf_av = 6'd40;

    // Phase 3 holds each request until its grant shows up
    repeat (8) begin
      trn_tcfg_req = 1'b1;
      waited = 0;
      do begin
        run_cycles(1, 1'b1);
        waited++;
      end while (owed != 0 && waited < GRANT_WAIT);
      if (owed != 0) begin
        $display("Config request was never granted");
        stop_failed();
      end
      trn_tcfg_req = 1'b0;
      run_cycles(5 + ($random(seed) & 15), 1'b1);
    end
    trn_tdst_rdy = 1'b1;

    // Phase 4 takes the link through L1 and back
    repeat (8) begin
      cfg_pcie_link_state = LINK_L0;
      run_cycles(3 + ($random(seed) & 7), 1'b0);
      // L1 entry is seen with no packet in flight
      idle_stream();
      cfg_pcie_link_state = LINK_PPM_L1_TRANS;
      clock_cycle();
      run_cycles(1, 1'b0);
      cfg_pcie_link_state = LINK_PPM_L1;
      run_cycles(2 + ($random(seed) & 7), 1'b0);
    end
    cfg_pcie_link_state = LINK_L0;
    run_cycles(10, 1'b0);

    // Phase 5 turns the link off with the user's consent
    user_turnoff_ok = 1'b1;
    cfg_to_turnoff  = 1'b1;
    run_cycles(1, 1'b0);
    cfg_to_turnoff = 1'b0;
    waited = 0;
    while (tok_count == 0 && waited < GRANT_WAIT) begin
      run_cycles(1, 1'b0);
      waited++;
    end
    if (tok_count == 0) begin
      $display("Turnoff was never granted");
      stop_failed();
    end
    run_cycles(100, 1'b0);

    if (owed == 0 && tok_count == 1) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Grant counts wrong at end of run");
      stop_failed();
    end
  end

endmodule

`default_nettype wire

//--- source/tx_thrtl_ctl.sv
`timescale 1ns/1ns
`default_nettype none

module tx_thrtl_ctl (
  input  logic                      user_clk,
  input  logic                      user_rst,
  input  tx_thrtl_pkg::axis_beat_t  s_axis_tx,
  input  logic                      user_tcfg_gnt,
  input  logic                      user_turnoff_ok,
  input  logic [5:0]                trn_tbuf_av,
  input  logic                      trn_tdst_rdy,
  input  logic                      trn_lnk_up,
  input  logic                      trn_tcfg_req,
  input  tx_thrtl_pkg::link_state_e cfg_pcie_link_state,
  input  logic                      cfg_to_turnoff,
  output logic                      trn_tcfg_gnt,
  output logic                      cfg_turnoff_ok,
  output logic                      tready_thrtl
);
  import tx_thrtl_pkg::*;

  // One cause per throttle reason
  thrtl_cause_t link;
  thrtl_cause_t min;
  thrtl_cause_t gap;
  thrtl_cause_t cfg;
  thrtl_cause_t l1;
  thrtl_cause_t l23;

  // Feedback from the state machine and between monitors
  logic in_throttle;
  logic cfg_exit;
  logic gnt_pending;
  logic turnoff_pending;

  // ------------------------------------------------------------
  // Reason monitors
  // ------------------------------------------------------------

  tbuf_link_monitor i_tbuf_link_monitor (
    .user_clk     (user_clk),
    .user_rst     (user_rst),
    .s_axis_tx    (s_axis_tx),
    .ready        (tready_thrtl),
    .in_throttle  (in_throttle),
    .cfg_exit     (cfg_exit),
    .trn_tbuf_av  (trn_tbuf_av),
    .trn_lnk_up   (trn_lnk_up),
    .trn_tdst_rdy (trn_tdst_rdy),
    .link         (link),
    .min          (min),
    .gap          (gap)
  );

  cfg_req_monitor i_cfg_req_monitor (
    .user_clk      (user_clk),
    .user_rst      (user_rst),
    .trn_tcfg_req  (trn_tcfg_req),
    .trn_tdst_rdy  (trn_tdst_rdy),
    .user_tcfg_gnt (user_tcfg_gnt),
    .tcfg_gnt      (trn_tcfg_gnt),
    .cfg           (cfg),
    .cfg_exit      (cfg_exit),
    .gnt_pending   (gnt_pending)
  );

  pm_state_monitor i_pm_state_monitor (
    .user_clk            (user_clk),
    .user_rst            (user_rst),
    .cfg_pcie_link_state (cfg_pcie_link_state),
    .cfg_to_turnoff      (cfg_to_turnoff),
    .user_turnoff_ok     (user_turnoff_ok),
    .turnoff_ok          (cfg_turnoff_ok),
    .l1                  (l1),
    .l23                 (l23),
    .turnoff_pending     (turnoff_pending)
  );

  // ------------------------------------------------------------
  // Throttle state machine
  // ------------------------------------------------------------

  thrtl_fsm i_thrtl_fsm (
    .user_clk        (user_clk),
    .user_rst        (user_rst),
    .s_axis_tx       (s_axis_tx),
    .link            (link),
    .min             (min),
    .gap             (gap),
    .cfg             (cfg),
    .l1              (l1),
    .l23             (l23),
    .gnt_pending     (gnt_pending),
    .turnoff_pending (turnoff_pending),
    .tready_thrtl    (tready_thrtl),
    .in_throttle     (in_throttle),
    .trn_tcfg_gnt    (trn_tcfg_gnt),
    .cfg_turnoff_ok  (cfg_turnoff_ok)
  );

endmodule

`default_nettype wire

//--- throttle/thrtl_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module thrtl_fsm (
  input  logic                       user_clk,
  input  logic                       user_rst,
  input  tx_thrtl_pkg::axis_beat_t   s_axis_tx,
  input  tx_thrtl_pkg::thrtl_cause_t link,
  input  tx_thrtl_pkg::thrtl_cause_t min,
  input  tx_thrtl_pkg::thrtl_cause_t gap,
  input  tx_thrtl_pkg::thrtl_cause_t cfg,
  input  tx_thrtl_pkg::thrtl_cause_t l1,
  input  tx_thrtl_pkg::thrtl_cause_t l23,
  input  logic                       gnt_pending,
  input  logic                       turnoff_pending,
  output logic                       tready_thrtl,
  output logic                       in_throttle,
  output logic                       trn_tcfg_gnt,
  output logic                       cfg_turnoff_ok
);

  typedef enum logic {
    ST_IDLE     = 1'b0,
    ST_THROTTLE = 1'b1
  } state_e;

  state_e state;
  state_e state_nxt;
  logic   ready_nxt;
  logic   in_pkt_q;
  logic   in_pkt;
  logic   pkt_ending;
  logic   thrtl_ok;
  logic   any_trig;
  logic   any_held;
  logic   take;
  logic   grant_window;
  logic   cfg_owed;

  // ------------------------------------------------------------
  // Packet tracking
  // ------------------------------------------------------------

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      in_pkt_q <= 1'b0;
    end else if (s_axis_tx.tvalid && s_axis_tx.tlast) begin
      in_pkt_q <= 1'b0;
    end else if (s_axis_tx.tvalid && tready_thrtl) begin
      in_pkt_q <= 1'b1;
    end
  end

  // Ready is registered, so this has to be true one cycle ahead
  // of the stall; cutting a packet in the middle is never allowed
  assign in_pkt     = s_axis_tx.tvalid || in_pkt_q;
  assign pkt_ending = s_axis_tx.tvalid && s_axis_tx.tlast;
  assign thrtl_ok   = !in_pkt || pkt_ending || !tready_thrtl;

  assign any_trig = link.trig || min.trig || gap.trig || cfg.trig || l1.trig || l23.trig;
  assign any_held = link.held || min.held || gap.held || cfg.held || l1.held || l23.held;

  // ------------------------------------------------------------
  // Next state and ready
  // ------------------------------------------------------------

  // Moving from IDLE into THROTTLE on a held cause
  assign take = (state == ST_IDLE) && any_held && thrtl_ok;

  always_comb begin
    state_nxt = state;
    ready_nxt = 1'b0;
    case (state)
      ST_IDLE: begin
        if (take) begin
          state_nxt = ST_THROTTLE;
        end else begin
          // Drop ready early on a fresh trigger without changing state
          ready_nxt = !(thrtl_ok && any_trig);
        end
      end
      ST_THROTTLE: begin
        // Leave only once every held flag has gone
        if (!any_held) begin
          state_nxt = ST_IDLE;
          ready_nxt = !any_trig;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      state        <= ST_THROTTLE;
      tready_thrtl <= 1'b0;
    end else begin
      state        <= state_nxt;
      tready_thrtl <= ready_nxt;
    end
  end

  assign in_throttle = (state == ST_THROTTLE);

  // ------------------------------------------------------------
  // Grants
  // ------------------------------------------------------------

  // Grants go out on entry to THROTTLE or while in it
  // The config grant wins when both are owed
  assign grant_window   = take || in_throttle;
  assign cfg_owed       = cfg.held && gnt_pending;
  assign trn_tcfg_gnt   = grant_window && cfg_owed;
  assign cfg_turnoff_ok = grant_window && !cfg_owed && turnoff_pending;

endmodule

`default_nettype wire

//--- throttle/pm_state_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module pm_state_monitor (
  input  logic                       user_clk,
  input  logic                       user_rst,
  input  tx_thrtl_pkg::link_state_e  cfg_pcie_link_state,
  input  logic                       cfg_to_turnoff,
  input  logic                       user_turnoff_ok,
  input  logic                       turnoff_ok,
  output tx_thrtl_pkg::thrtl_cause_t l1,
  output tx_thrtl_pkg::thrtl_cause_t l23,
  output logic                       turnoff_pending
);
  import tx_thrtl_pkg::*;

  link_state_e link_state_d;
  logic        l1_trig;
  logic        l1_held;
  logic        to_turnoff_q;
  logic        user_ok_q;
  logic        l23_trig;
  logic        l23_held;

  // ------------------------------------------------------------
  // PPM L1 entry
  // ------------------------------------------------------------

  // Entry shows up as L0 followed directly by the L1 transition code
  assign l1_trig = (link_state_d == LINK_L0) &&
                   (cfg_pcie_link_state == LINK_PPM_L1_TRANS);

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      l1_held      <= 1'b0;
      link_state_d <= LINK_L0;
    end else begin
      if (l1_trig) begin
        l1_held <= 1'b1;
      end else if (cfg_pcie_link_state == LINK_L0) begin
        l1_held <= 1'b0;
      end
      link_state_d <= cfg_pcie_link_state;
    end
  end

  // ------------------------------------------------------------
  // L2/3 turnoff
  // ------------------------------------------------------------

  // The block pulses cfg_to_turnoff only once, so it is caught here
  // and kept until reset
  assign l23_trig = to_turnoff_q && user_ok_q;

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      to_turnoff_q    <= 1'b0;
      user_ok_q       <= 1'b0;
      l23_held        <= 1'b0;
      turnoff_pending <= 1'b0;
    end else begin
      if (cfg_to_turnoff) begin
        to_turnoff_q <= 1'b1;
      end
      user_ok_q <= user_turnoff_ok;

      // Nothing leaves L2/3 except a full reset
      if (l23_trig) begin
        l23_held <= 1'b1;
      end

      // The first trigger alone owes the block its one turnoff grant
      if (l23_trig && !l23_held) begin
        turnoff_pending <= 1'b1;
      end else if (turnoff_ok) begin
        turnoff_pending <= 1'b0;
      end
    end
  end

  assign l1  = '{trig: l1_trig, held: l1_held};
  assign l23 = '{trig: l23_trig, held: l23_held};

endmodule

`default_nettype wire

//--- throttle/cfg_req_monitor.sv
`timescale 1ns/1ns
`default_nettype none
`include "tx_thrtl_defs.svh"

module cfg_req_monitor (
  input  logic                       user_clk,
  input  logic                       user_rst,
  input  logic                       trn_tcfg_req,
  input  logic                       trn_tdst_rdy,
  input  logic                       user_tcfg_gnt,
  input  logic                       tcfg_gnt,
  output tx_thrtl_pkg::thrtl_cause_t cfg,
  output logic                       cfg_exit,
  output logic                       gnt_pending
);

  logic       user_gnt_q;
  logic       req_d;
  logic       dst_rdy_d;
  logic       req_rise;
  logic [1:0] lat_cnt;
  logic       cfg_trig;
  logic       cfg_held;
  logic       exit_seen;

  // ------------------------------------------------------------
  // Request detection
  // ------------------------------------------------------------

  // The user permission is registered before it can trigger anything
  assign cfg_trig = trn_tcfg_req && user_gnt_q;
  assign req_rise = trn_tcfg_req && !req_d;

  // Once the grant has had time to sink in, the block keeps
  // destination ready low until the response is out
  // Its return high marks the end of the response
  assign exit_seen = (lat_cnt == 2'd0) && !dst_rdy_d && trn_tdst_rdy;

  // Only an exit of an active throttle feeds the gap reason
  assign cfg_exit = cfg_held && exit_seen;

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      cfg_held    <= 1'b0;
      gnt_pending <= 1'b0;
      lat_cnt     <= 2'd0;
      user_gnt_q  <= 1'b0;
      req_d       <= 1'b0;
      dst_rdy_d   <= 1'b1;
    end else begin
      if (cfg_trig) begin
        cfg_held <= 1'b1;
      end else if (exit_seen) begin
        cfg_held <= 1'b0;
      end

      // Each request edge is owed exactly one grant pulse
      if (req_rise) begin
        gnt_pending <= 1'b1;
      end else if (tcfg_gnt) begin
        gnt_pending <= 1'b0;
      end

      // Latency timer restarts while a grant is still outstanding
      if (req_rise || gnt_pending) begin
        lat_cnt <= `TCFG_LATENCY_TIME;
      end else if (lat_cnt != 2'd0) begin
        lat_cnt <= lat_cnt - 2'd1;
      end

      user_gnt_q <= user_tcfg_gnt;
      req_d      <= trn_tcfg_req;
      dst_rdy_d  <= trn_tdst_rdy;
    end
  end

  assign cfg = '{trig: cfg_trig, held: cfg_held};

endmodule

`default_nettype wire

//--- throttle/tbuf_link_monitor.sv
`timescale 1ns/1ns
`default_nettype none
`include "tx_thrtl_defs.svh"

module tbuf_link_monitor (
  input  logic                       user_clk,
  input  logic                       user_rst,
  input  tx_thrtl_pkg::axis_beat_t   s_axis_tx,
  input  logic                       ready,
  input  logic                       in_throttle,
  input  logic                       cfg_exit,
  input  logic [5:0]                 trn_tbuf_av,
  input  logic                       trn_lnk_up,
  input  logic                       trn_tdst_rdy,
  output tx_thrtl_pkg::thrtl_cause_t link,
  output tx_thrtl_pkg::thrtl_cause_t min,
  output tx_thrtl_pkg::thrtl_cause_t gap
);

  logic       link_trig;
  logic       link_held;
  logic       min_trig;
  logic       min_held;
  logic       gap_trig_tlast;
  logic       gap_trig_decr;
  logic       gap_trig;
  logic       gap_held;
  logic [2:0] gap_cnt;
  logic [5:0] tbuf_av_d;

  // ------------------------------------------------------------
  // Link down
  // ------------------------------------------------------------

  // Held from reset until the block first reports destination ready
  assign link_trig = !trn_lnk_up;

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      link_held <= 1'b1;
    end else if (link_trig) begin
      link_held <= 1'b1;
    end else if (trn_tdst_rdy) begin
      link_held <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // Buffers at the minimum
  // ------------------------------------------------------------

  // The held flag simply tracks the compare one cycle late
  assign min_trig = (trn_tbuf_av <= `TBUF_AV_MIN);

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      min_held <= 1'b0;
    end else begin
      min_held <= min_trig;
    end
  end

  // ------------------------------------------------------------
  // Buffers near the gap threshold
  // ------------------------------------------------------------

  // A packet just finished while buffers are low, so let it soak in
  assign gap_trig_tlast = (trn_tbuf_av <= `TBUF_AV_GAP) && s_axis_tx.tvalid &&
                          s_axis_tx.tlast && ready;

  // The count just stepped down onto the threshold
  assign gap_trig_decr = (trn_tbuf_av == `TBUF_AV_GAP) &&
                         (tbuf_av_d == (`TBUF_AV_GAP + 6'd1));

  // A finished config response also used buffers behind our back
  assign gap_trig = gap_trig_tlast || gap_trig_decr || cfg_exit;

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      gap_held  <= 1'b0;
      gap_cnt   <= 3'd0;
      tbuf_av_d <= 6'd0;
    end else begin
      if (gap_trig) begin
        gap_held <= 1'b1;
      end else if (gap_cnt == 3'd0) begin
        gap_held <= 1'b0;
      end
      // Count only while the user is really stalled for this reason
      if (gap_held && in_throttle) begin
        if (gap_cnt != 3'd0) begin
          gap_cnt <= gap_cnt - 3'd1;
        end
      end else begin
        gap_cnt <= `TBUF_GAP_TIME;
      end
      tbuf_av_d <= trn_tbuf_av;
    end
  end

  assign link = '{trig: link_trig, held: link_held};
  assign min  = '{trig: min_trig, held: min_held};
  assign gap  = '{trig: gap_trig, held: gap_held};

endmodule

`default_nettype wire

//--- common/tx_thrtl_pkg.sv
`default_nettype none

package tx_thrtl_pkg;

  // ------------------------------------------------------------
  // Link-state code reported by the block
  // ------------------------------------------------------------

  // Only the codes the endpoint throttle cares about are named
  // Other codes can appear on the wire and simply match nothing
  typedef enum logic [2:0] {
    LINK_L0             = 3'b000,
    LINK_PPM_L1         = 3'b001,
    LINK_PPM_L1_TRANS   = 3'b101,
    LINK_PPM_L23R_TRANS = 3'b110
  } link_state_e;

  // ------------------------------------------------------------
  // User stream control bits
  // ------------------------------------------------------------

  // The throttle never looks at data, so a beat is just these two bits
  typedef struct packed {
    logic tvalid;
    logic tlast;
  } axis_beat_t;

  // ------------------------------------------------------------
  // One throttle reason as seen by the state machine
  // ------------------------------------------------------------

  // The trigger is combinational and lets the machine drop ready
  // as early as possible
  // The held flag is registered and keeps the machine in THROTTLE
  typedef struct packed {
    logic trig;
    logic held;
  } thrtl_cause_t;

endpackage

`default_nettype wire

//--- common/tx_thrtl_defs.svh
`ifndef TX_THRTL_DEFS_SVH
`define TX_THRTL_DEFS_SVH

// ------------------------------------------------------------
// Transmit throttle sizing
// ------------------------------------------------------------

// Width of the user transmit stream, either 64 or 128
// The buffer thresholds below are the only things derived from it
`define TX_DATA_WIDTH 64

// Buffer count at or below which the user is held off
`define TBUF_AV_MIN ((`TX_DATA_WIDTH == 128) ? 6'd5 : 6'd1)

// Near-empty threshold, one above the minimum
`define TBUF_AV_GAP (`TBUF_AV_MIN + 6'd1)

// Throttled cycles a packet gets to soak into the block before the
// buffer count is trusted again
`define TBUF_GAP_TIME ((`TX_DATA_WIDTH == 128) ? 3'd4 : 3'd1)

// Cycles for a configuration grant to sink into the block
`define TCFG_LATENCY_TIME 2'd2

`endif
